//--- src/fmul_pkg.sv
// Floating-point multiply package
`default_nettype none

package fmul_pkg;

    // ==============================
    // Field types
    // ==============================

    // Raw IEEE-754 single-precision word
    typedef logic [31:0] float_word_t;

    // Biased exponent field
    typedef logic [7:0] exponent_t;

    // Stored fraction without the hidden bit
    typedef logic [22:0] significand_t;

    // Guard, round and sticky bits with guard as the MSB
    typedef logic [2:0] round_bits_t;

    // ==============================
    // Constants
    // ==============================

    localparam exponent_t BIAS = 8'd127;

    // Quiet NaN returned for every invalid operation
    localparam float_word_t CANONICAL_NAN = 32'h7FC0_0000;

    // ==============================
    // Control FSM
    // ==============================

    // One operation per four-phase handshake
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        ISSUE = 2'b01,
        BUSY  = 2'b10,
        HOLD  = 2'b11
    } fmul_state_t;

endpackage : fmul_pkg

`default_nettype wire

//--- src/float_classifier.sv
// Operand classifier
`default_nettype none

module float_classifier (
    input  fmul_pkg::float_word_t operand_i,
    output logic                  is_zero_o,
    output logic                  is_subnormal_o,
    output logic                  is_infinity_o,
    output logic                  is_nan_o
);

    import fmul_pkg::*;

    exponent_t    exponent;
    significand_t fraction;
    logic         exp_all_zero;
    logic         exp_all_ones;
    logic         frac_zero;

    // Only the exponent and fraction fields decide the class
    assign exponent = operand_i[30:23];
    assign fraction = operand_i[22:0];

    assign exp_all_zero = (exponent == '0);
    assign exp_all_ones = (exponent == '1);
    assign frac_zero    = (fraction == '0);

    // An all-zeros exponent is zero or subnormal depending on the fraction
    assign is_zero_o      = exp_all_zero & frac_zero;
    assign is_subnormal_o = exp_all_zero & ~frac_zero;

    // An all-ones exponent is infinity or a NaN of either kind
    assign is_infinity_o = exp_all_ones & frac_zero;
    assign is_nan_o      = exp_all_ones & ~frac_zero;

endmodule : float_classifier

`default_nettype wire

//--- src/significand_multiplier.sv
// Pipelined significand multiplier
`default_nettype none

module significand_multiplier #(
    parameter int CORE_STAGES = 2
) (
    input  logic        clk_i,
    input  logic [23:0] a_i,
    input  logic [23:0] b_i,
    output logic [47:0] product_o
);

    // Full unsigned 24 x 24 product
    logic [47:0] product;

    assign product = a_i * b_i;

    generate
        if (CORE_STAGES == 0) begin : g_comb
            // Without stages the core is purely combinational
            assign product_o = product;
        end else begin : g_pipe
            // Delay line that retiming can push back into the partial products
            logic [47:0] product_pipe [CORE_STAGES];

            always_ff @(posedge clk_i) begin
                product_pipe[0] <= product;
                for (int i = 1; i < CORE_STAGES; i++) begin
                    product_pipe[i] <= product_pipe[i-1];
                end
            end

            assign product_o = product_pipe[CORE_STAGES-1];
        end
    endgenerate

endmodule : significand_multiplier

`default_nettype wire

//--- src/float_multiplier.sv
// Floating-point multiplier datapath
`default_nettype none

module float_multiplier #(
    parameter int CORE_STAGES = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  fmul_pkg::float_word_t multiplicand_i,
    input  fmul_pkg::float_word_t multiplier_i,
    input  logic                  is_infinity_a_i,
    input  logic                  is_infinity_b_i,
    input  logic                  is_nan_a_i,
    input  logic                  is_nan_b_i,
    input  logic                  is_zero_a_i,
    input  logic                  is_zero_b_i,
    input  logic                  is_subnormal_a_i,
    input  logic                  is_subnormal_b_i,
    input  logic                  valid_i,
    output fmul_pkg::float_word_t result_o,
    output fmul_pkg::round_bits_t round_bits_o,
    output logic                  valid_o,
    output logic                  invalid_o,
    output logic                  overflow_o,
    output logic                  underflow_o
);

    import fmul_pkg::*;

    // ==============================
    // Input stage
    // ==============================

    logic             result_sign;
    logic             invalid_op;
    logic signed [9:0] exp_sum;

    assign result_sign = multiplicand_i[31] ^ multiplier_i[31];

    // NaN on either side, or infinity against zero, has no defined product
    assign invalid_op = is_nan_a_i | is_nan_b_i
                      | (is_infinity_a_i & is_zero_b_i)
                      | (is_infinity_b_i & is_zero_a_i);

    // Two extra bits keep the sum of biased exponents exact and signed
    assign exp_sum = $signed({2'b00, multiplicand_i[30:23]})
                   + $signed({2'b00, multiplier_i[30:23]})
                   - $signed({2'b00, BIAS});

    // ==============================
    // Side pipeline
    // ==============================

    // Everything the normaliser needs waits as long as the product does
    logic [CORE_STAGES:0] sign_pipe;
    logic [CORE_STAGES:0] invalid_pipe;
    logic [CORE_STAGES:0] infinity_pipe;
    logic [CORE_STAGES:0] zero_pipe;
    logic [CORE_STAGES:0] valid_pipe;
    logic signed [9:0]    exp_pipe [CORE_STAGES+1];

    always_ff @(posedge clk_i) begin
        sign_pipe[0]     <= result_sign;
        invalid_pipe[0]  <= invalid_op;
        infinity_pipe[0] <= is_infinity_a_i | is_infinity_b_i;
        zero_pipe[0]     <= is_zero_a_i | is_zero_b_i;
        exp_pipe[0]      <= exp_sum;
        for (int i = 1; i <= CORE_STAGES; i++) begin
            sign_pipe[i]     <= sign_pipe[i-1];
            invalid_pipe[i]  <= invalid_pipe[i-1];
            infinity_pipe[i] <= infinity_pipe[i-1];
            zero_pipe[i]     <= zero_pipe[i-1];
            exp_pipe[i]      <= exp_pipe[i-1];
        end
    end

    // Valid shifts alongside the data and marks the occupied stages
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= valid_i;
            for (int i = 1; i <= CORE_STAGES; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign valid_o = valid_pipe[CORE_STAGES];

    // ==============================
    // Significand product
    // ==============================

    logic [47:0] product;
    logic [47:0] product_q;

    // A subnormal operand enters the core without its hidden one
    significand_multiplier #(
        .CORE_STAGES (CORE_STAGES)
    ) significand_multiplier_i (
        .clk_i     (clk_i),
        .a_i       ({~is_subnormal_a_i, multiplicand_i[22:0]}),
        .b_i       ({~is_subnormal_b_i, multiplier_i[22:0]}),
        .product_o (product)
    );

    // One more register lines the product up with the last side stage
    always_ff @(posedge clk_i) begin
        product_q <= product;
    end

    // ==============================
    // Normalisation
    // ==============================

    logic signed [9:0] exp_norm;
    significand_t      frac_norm;
    round_bits_t       round_norm;
    logic              sign_out;

    assign sign_out = sign_pipe[CORE_STAGES];

    // A product of two values in [1,2) lies in [1,4) and bit 47 marks the upper half
    assign exp_norm = exp_pipe[CORE_STAGES] + $signed({9'd0, product_q[47]});

    always_comb begin
        if (product_q[47]) begin
            frac_norm  = product_q[46:24];
            round_norm = {product_q[23:22], |product_q[21:0]};
        end else begin
            frac_norm  = product_q[45:23];
            round_norm = {product_q[22:21], |product_q[20:0]};
        end
    end

    // Special operands win over range checks and overflow wins over underflow
    always_comb begin
        invalid_o    = invalid_pipe[CORE_STAGES];
        overflow_o   = 1'b0;
        underflow_o  = 1'b0;
        round_bits_o = '0;
        if (invalid_pipe[CORE_STAGES]) begin
            result_o = CANONICAL_NAN;
        end else if (infinity_pipe[CORE_STAGES]) begin
            result_o   = {sign_out, 8'hFF, 23'd0};
            overflow_o = 1'b1;
        end else if (zero_pipe[CORE_STAGES]) begin
            result_o = {sign_out, 31'd0};
        end else if (exp_norm > 10'sd254) begin
            result_o   = {sign_out, 8'hFF, 23'd0};
            overflow_o = 1'b1;
        end else if (exp_norm < 10'sd1) begin
            // Below the normal range the result flushes to a signed zero
            result_o    = {sign_out, 31'd0};
            underflow_o = 1'b1;
        end else begin
            result_o     = {sign_out, exp_norm[7:0], frac_norm};
            round_bits_o = round_norm;
        end
    end

endmodule : float_multiplier

`default_nettype wire

//--- src/float_rounder.sv
// Round to nearest even stage
`default_nettype none

module float_rounder (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  fmul_pkg::float_word_t result_i,
    input  fmul_pkg::round_bits_t round_bits_i,
    input  logic                  valid_i,
    input  logic                  invalid_i,
    input  logic                  overflow_i,
    input  logic                  underflow_i,
    output fmul_pkg::float_word_t rounded_o,
    output logic                  done_o,
    output logic                  invalid_o,
    output logic                  overflow_o,
    output logic                  underflow_o,
    output logic                  inexact_o
);

    import fmul_pkg::*;

    logic        round_up;
    logic [30:0] magnitude;
    exponent_t   rounded_exp;
    logic        carry_to_inf;

    // Above halfway always rounds up, exactly halfway only for an odd LSB
    assign round_up = round_bits_i[2] & (round_bits_i[1] | round_bits_i[0] | result_i[0]);

    // A fraction carry ripples straight into the exponent field
    assign magnitude   = result_i[30:0] + 31'(round_up);
    assign rounded_exp = magnitude[30:23];

    // The fraction wraps to zero here, so the word is already infinity
    assign carry_to_inf = round_up & (rounded_exp == '1);

    always_ff @(posedge clk_i) begin
        rounded_o   <= {result_i[31], magnitude};
        invalid_o   <= invalid_i;
        overflow_o  <= overflow_i | carry_to_inf;
        underflow_o <= underflow_i;
        inexact_o   <= |round_bits_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= valid_i;
        end
    end

endmodule : float_rounder

`default_nettype wire

//--- src/fmul_control.sv
// Multiply handshake controller
`default_nettype none

module fmul_control (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_i,
    input  fmul_pkg::float_word_t a_i,
    input  fmul_pkg::float_word_t b_i,
    input  logic                  done_i,
    input  fmul_pkg::float_word_t rounded_i,
    input  logic                  invalid_i,
    input  logic                  overflow_i,
    input  logic                  underflow_i,
    input  logic                  inexact_i,
    output logic                  ack_o,
    output fmul_pkg::float_word_t op_a_o,
    output fmul_pkg::float_word_t op_b_o,
    output logic                  issue_o,
    output fmul_pkg::float_word_t result_o,
    output logic                  invalid_o,
    output logic                  overflow_o,
    output logic                  underflow_o,
    output logic                  inexact_o
);

    import fmul_pkg::*;

    fmul_state_t state_q;
    fmul_state_t state_d;

    // ==============================
    // State machine
    // ==============================

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:  if (req_i) state_d = ISSUE;
            ISSUE: state_d = BUSY;
            BUSY:  if (done_i) state_d = HOLD;
            HOLD:  if (!req_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            issue_o <= 1'b0;
        end else begin
            state_q <= state_d;
            // The issue pulse is high for the first BUSY cycle
            issue_o <= (state_q == ISSUE);
        end
    end

    // Acknowledge is high for the whole HOLD state
    assign ack_o = (state_q == HOLD);

    // ==============================
    // Operand and result registers
    // ==============================

    // Operands stay put for the whole operation once accepted
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_i) begin
            op_a_o <= a_i;
            op_b_o <= b_i;
        end
    end

    // Result and flags hold from the rise of ack until the next result arrives
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_o    <= '0;
            invalid_o   <= 1'b0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
            inexact_o   <= 1'b0;
        end else if (state_q == BUSY && done_i) begin
            result_o    <= rounded_i;
            invalid_o   <= invalid_i;
            overflow_o  <= overflow_i;
            underflow_o <= underflow_i;
            inexact_o   <= inexact_i;
        end
    end

endmodule : fmul_control

`default_nettype wire

//--- src/fmul_unit.sv
// Floating-point multiply unit
`default_nettype none

module fmul_unit #(
    parameter int CORE_STAGES = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_i,
    input  fmul_pkg::float_word_t a_i,
    input  fmul_pkg::float_word_t b_i,
    output logic                  ack_o,
    output fmul_pkg::float_word_t result_o,
    output logic                  invalid_o,
    output logic                  overflow_o,
    output logic                  underflow_o,
    output logic                  inexact_o
);

    import fmul_pkg::*;

    float_word_t op_a;
    float_word_t op_b;
    logic        issue;
    logic        zero_a, subnormal_a, infinity_a, nan_a;
    logic        zero_b, subnormal_b, infinity_b, nan_b;

    // Multiplier to rounder
    float_word_t mul_result;
    round_bits_t mul_round_bits;
    logic        mul_valid, mul_invalid, mul_overflow, mul_underflow;

    // Rounder back to control
    float_word_t rounded;
    logic        done, rnd_invalid, rnd_overflow, rnd_underflow, rnd_inexact;

    fmul_control fmul_control_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .done_i      (done),
        .rounded_i   (rounded),
        .invalid_i   (rnd_invalid),
        .overflow_i  (rnd_overflow),
        .underflow_i (rnd_underflow),
        .inexact_i   (rnd_inexact),
        .ack_o       (ack_o),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .issue_o     (issue),
        .result_o    (result_o),
        .invalid_o   (invalid_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o),
        .inexact_o   (inexact_o)
    );

    float_classifier classifier_a_i (
        .operand_i      (op_a),
        .is_zero_o      (zero_a),
        .is_subnormal_o (subnormal_a),
        .is_infinity_o  (infinity_a),
        .is_nan_o       (nan_a)
    );

    float_classifier classifier_b_i (
        .operand_i      (op_b),
        .is_zero_o      (zero_b),
        .is_subnormal_o (subnormal_b),
        .is_infinity_o  (infinity_b),
        .is_nan_o       (nan_b)
    );

    float_multiplier #(
        .CORE_STAGES (CORE_STAGES)
    ) float_multiplier_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .multiplicand_i   (op_a),
        .multiplier_i     (op_b),
        .is_infinity_a_i  (infinity_a),
        .is_infinity_b_i  (infinity_b),
        .is_nan_a_i       (nan_a),
        .is_nan_b_i       (nan_b),
        .is_zero_a_i      (zero_a),
        .is_zero_b_i      (zero_b),
        .is_subnormal_a_i (subnormal_a),
        .is_subnormal_b_i (subnormal_b),
        .valid_i          (issue),
        .result_o         (mul_result),
        .round_bits_o     (mul_round_bits),
        .valid_o          (mul_valid),
        .invalid_o        (mul_invalid),
        .overflow_o       (mul_overflow),
        .underflow_o      (mul_underflow)
    );

    float_rounder float_rounder_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .result_i     (mul_result),
        .round_bits_i (mul_round_bits),
        .valid_i      (mul_valid),
        .invalid_i    (mul_invalid),
        .overflow_i   (mul_overflow),
        .underflow_i  (mul_underflow),
        .rounded_o    (rounded),
        .done_o       (done),
        .invalid_o    (rnd_invalid),
        .overflow_o   (rnd_overflow),
        .underflow_o  (rnd_underflow),
        .inexact_o    (rnd_inexact)
    );

endmodule : fmul_unit

`default_nettype wire

//--- verif/fmul_unit_tb.sv
// Floating-point multiply unit testbench
`default_nettype none

module fmul_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import fmul_pkg::*;

    localparam int CORE_STAGES = 2;
    localparam int TIMEOUT     = 100;

    logic        clk_i;
    logic        rst_n_i;
    logic        req_i;
    float_word_t a_i;
    float_word_t b_i;
    logic        ack_o;
    float_word_t result_o;
    logic        invalid_o;
    logic        overflow_o;
    logic        underflow_o;
    logic        inexact_o;

    int          errors;
    int          vectors;
    int          failed_vectors;
    bit          aborted;
    float_word_t last_result;
    logic [3:0]  last_flags;

    fmul_unit #(
        .CORE_STAGES (CORE_STAGES)
    ) fmul_unit_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .ack_o       (ack_o),
        .result_o    (result_o),
        .invalid_o   (invalid_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o),
        .inexact_o   (inexact_o)
    );

    // 8 ns clock period
    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    // ==============================
    // Helpers
    // ==============================

    // Flag nibble in the same order as the vector file
    function automatic logic [3:0] flags_now();
        return {invalid_o, overflow_o, underflow_o, inexact_o};
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0.1f ns: %s expected %08h, got %08h",
                     $realtime, name, expected, actual);
            errors++;
        end
    endtask

    // Counts rising edges after the caller's edge until ack_o reaches the level
    // Sampling happens on the falling edge where the outputs are settled
    task automatic wait_for_ack(input logic level, output int edges, output bit timed_out);
        edges = 0;
        @(negedge clk_i);
        while (ack_o !== level && edges < TIMEOUT) begin
            @(negedge clk_i);
            edges++;
        end
        timed_out = (ack_o !== level);
    endtask

    // Random pause between operations in which the last result must hold
    task automatic idle_gap(input float_word_t held_result, input logic [3:0] held_flags);
        int gap;
        gap = $urandom % 6;
        repeat (gap) begin
            @(negedge clk_i);
            compare("ack_o", 32'd0, ack_o);
            compare("result_o", held_result, result_o);
            compare("invalid_o/overflow_o/underflow_o/inexact_o", held_flags, flags_now());
        end
    endtask

    // ==============================
    // One full handshake
    // ==============================

    task automatic run_vector(input float_word_t op_a, input float_word_t op_b,
                              input float_word_t exp_result, input logic [3:0] exp_flags);
        int          edges;
        bit          timed_out;
        int          errors_before;
        int          hold;
        float_word_t got_result;
        logic [3:0]  got_flags;
        errors_before = errors;
        got_result    = '0;
        got_flags     = '0;
        @(posedge clk_i);
        a_i   <= op_a;
        b_i   <= op_b;
        req_i <= 1'b1;
        // The next edge samples the request while the controller is in IDLE
        @(posedge clk_i);
        wait_for_ack(1'b1, edges, timed_out);
        if (timed_out) begin
            $display("Timeout: ack_o did not rise within %0d cycles on vector %0d",
                     TIMEOUT, vectors);
            aborted = 1'b1;
        end else begin
            compare("ack_o latency", CORE_STAGES + 4, edges);
            compare("result_o", exp_result, result_o);
            compare("invalid_o/overflow_o/underflow_o/inexact_o", exp_flags, flags_now());
            got_result = result_o;
            got_flags  = flags_now();
            // Req stays high for a while and ack and the result have to stay put
            hold = $urandom % 6;
            repeat (hold) begin
                @(negedge clk_i);
                compare("ack_o", 32'd1, ack_o);
                compare("result_o", got_result, result_o);
                compare("invalid_o/overflow_o/underflow_o/inexact_o", got_flags, flags_now());
            end
            @(posedge clk_i);
            req_i <= 1'b0;
            @(posedge clk_i);
            wait_for_ack(1'b0, edges, timed_out);
            if (timed_out) begin
                $display("Timeout: ack_o did not fall within %0d cycles on vector %0d",
                         TIMEOUT, vectors);
                aborted = 1'b1;
            end else begin
                // Ack drops on the very edge that sees req low
                compare("ack_o fall delay", 32'd0, edges);
            end
        end
        last_result = got_result;
        last_flags  = got_flags;
        if (errors != errors_before || timed_out) begin
            failed_vectors++;
        end
        $display("Vector %0d: a=%08h b=%08h result=%08h flags=%01h %s", vectors, op_a, op_b,
                 got_result, got_flags,
                 (errors != errors_before || timed_out) ? "fail" : "pass");
        vectors++;
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int                 fd;
        int                 fields;
        logic [8*200-1:0]   line;
        float_word_t        vec_a;
        float_word_t        vec_b;
        float_word_t        vec_result;
        logic [3:0]         vec_flags;
        void'($urandom(86198));
        errors         = 0;
        vectors        = 0;
        failed_vectors = 0;
        aborted        = 1'b0;
        last_result    = '0;
        last_flags     = '0;
        rst_n_i        = 1'b0;
        req_i          = 1'b0;
        a_i            = '0;
        b_i            = '0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        // Outputs come out of reset cleared
        compare("ack_o", 32'd0, ack_o);
        compare("result_o", 32'd0, result_o);
        compare("invalid_o/overflow_o/underflow_o/inexact_o", 32'd0, flags_now());
        fd = $fopen("verif/fmul_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file verif/fmul_testdata.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && !$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    // Comment and blank lines do not parse as four hex fields
                    fields = $sscanf(line, "%h %h %h %h", vec_a, vec_b, vec_result, vec_flags);
                    if (fields == 4) begin
                        idle_gap(last_result, last_flags);
                        run_vector(vec_a, vec_b, vec_result, vec_flags);
                    end
                end
            end
            $fclose(fd);
        end
        if (vectors == 0 && !aborted) begin
            $display("No vectors were found in verif/fmul_testdata.txt");
            aborted = 1'b1;
        end
        $display("Summary: %0d vectors, %0d passed, %0d failed, %0d errors",
                 vectors, vectors - failed_vectors, failed_vectors, errors);
        if (errors == 0 && !aborted) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : fmul_unit_tb

`default_nettype wire

//--- verif/fmul_testdata.txt
// Columns: operand_a operand_b expected_result expected_flags, all hex
// Flag nibble bits from MSB: invalid overflow underflow inexact
3F800000 3F800000 3F800000 0
40000000 40400000 40C00000 0
3FC00000 3FC00000 40100000 0
C0000000 40800000 C1000000 0
3F000000 3E800000 3E000000 0
3EAAAAAB 40400000 3F800000 1
C0400000 3EAAAAAB BF800000 1
3DCCCCCD 41200000 3F800000 1
3F800001 3FC00000 3FC00002 1
3F800003 3FC00000 3FC00004 1
3FFFFFFF 3FFFFFFF 407FFFFE 1
3FC00001 3FC00000 40100001 1
3FFFFFFE 3F800001 40000000 1
7F7FFFFE 3F800001 7F800000 5
7FC00000 3F800000 7FC00000 8
7F800001 40000000 7FC00000 8
3F800000 FFC00001 7FC00000 8
7F800000 00000000 7FC00000 8
80000000 FF800000 7FC00000 8
7F800000 7FC00000 7FC00000 8
7F800000 40000000 7F800000 4
FF800000 40400000 FF800000 4
7F800000 FF800000 FF800000 4
7F800000 00000001 7F800000 4
00000000 40A00000 00000000 0
80000000 3F800000 80000000 0
00000000 C0400000 80000000 0
7F000000 7F000000 7F800000 4
FF000000 40000000 FF800000 4
5F800000 5F800000 7F800000 4
5F800000 5F000000 7F000000 0
7F7FFFFF 3F800000 7F7FFFFF 0
00800000 3F000000 00000000 2
80800000 00800000 80000000 2
1F800000 20000000 00000000 2
20000000 20000000 00800000 0
00000001 3F800000 00000000 2

//--- sim.f
src/fmul_pkg.sv
src/float_classifier.sv
src/significand_multiplier.sv
src/float_multiplier.sv
src/float_rounder.sv
src/fmul_control.sv
src/fmul_unit.sv
verif/fmul_unit_tb.sv

//--- Bender.yml
package:
  name: fmul_unit

sources:
  # Package first, then the blocks, then the top level
  - src/fmul_pkg.sv
  - src/float_classifier.sv
  - src/significand_multiplier.sv
  - src/float_multiplier.sv
  - src/float_rounder.sv
  - src/fmul_control.sv
  - src/fmul_unit.sv

  # Simulation only
  - target: test
    files:
      - verif/fmul_unit_tb.sv
